// File: Bender.yml
package:
  name: video_crop

sources:
  - files:
      - hdl/video_pkg.sv
      - hdl/axil_pkg.sv
      - hdl/crop_cfg_regs.sv
      - hdl/pixel_fifo.sv
      - hdl/crop_ctrl.sv
      - hdl/video_crop_top.sv
  - target: simulation
    files:
      - sim/video_crop_props.sv
      - sim/tb_video_crop.sv

// File: hdl/axil_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite definitions for the crop engine
// channel structs, register map and the configuration record
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package axil_pkg;
  import video_pkg::*;

  localparam int AXIL_ADDR_W = 8;
  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // register map
  localparam logic [AXIL_ADDR_W-1:0] REG_CTRL      = 8'h00;
  localparam logic [AXIL_ADDR_W-1:0] REG_IN_DIM    = 8'h04;
  localparam logic [AXIL_ADDR_W-1:0] REG_WIN_START = 8'h08;
  localparam logic [AXIL_ADDR_W-1:0] REG_OUT_DIM   = 8'h0C;
  localparam logic [AXIL_ADDR_W-1:0] REG_FILL      = 8'h10;
  localparam logic [AXIL_ADDR_W-1:0] REG_STATUS    = 8'h14;

  // second geometry field and frame count sit in the upper half
  localparam int DIM_HI_LSB   = 16;
  localparam int STAT_CNT_LSB = 16;
  localparam int FRAME_CNT_W  = 16;

  typedef struct packed {
    logic [AXIL_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic [AXIL_DATA_W-1:0] wdata;
    logic [AXIL_STRB_W-1:0] wstrb;
    logic                   wvalid;
    logic                   bready;
    logic [AXIL_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   rready;
  } axil_req_t;

  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   arready;
    logic [AXIL_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
  } axil_rsp_t;

  typedef struct packed {
    logic   enable;
    dim_t   in_w;
    dim_t   in_h;
    dim_t   start_x;
    dim_t   start_y;
    dim_t   out_w;
    dim_t   out_h;
    pixel_t fill;
  } crop_cfg_t;

endpackage

// File: hdl/crop_cfg_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Crop configuration registers
// AXI4-Lite slave with geometry, fill value, enable and a
// status word holding a sticky done flag and a frame count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module crop_cfg_regs
  import video_pkg::*;
  import axil_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst_n,
  input  axil_req_t i_axil,
  output axil_rsp_t o_axil,
  input  logic      i_frame_done,
  output crop_cfg_t o_cfg
);

  logic                   aw_pend;
  logic [AXIL_ADDR_W-1:0] aw_addr_q;
  logic                   w_pend;
  logic [AXIL_DATA_W-1:0] w_data_q;
  logic [AXIL_STRB_W-1:0] w_strb_q;
  logic                   aw_hs;
  logic                   w_hs;
  logic                   ar_hs;
  logic                   wr_en;
  logic [AXIL_ADDR_W-1:0] wr_addr;
  logic [AXIL_DATA_W-1:0] wr_data;
  logic [AXIL_STRB_W-1:0] wr_strb;
  logic [AXIL_DATA_W-1:0] wr_old;
  logic [AXIL_DATA_W-1:0] wr_val;
  logic                   bvalid_q;
  logic                   rvalid_q;
  logic [AXIL_DATA_W-1:0] rdata_q;
  crop_cfg_t              cfg_q;
  logic                   done_q;
  logic [FRAME_CNT_W-1:0] frame_cnt_q;

  function automatic logic [AXIL_DATA_W-1:0] reg_read(input logic [AXIL_ADDR_W-1:0] addr);
    logic [AXIL_DATA_W-1:0] val;
    val = '0;
    case (addr)
      REG_CTRL: val[0] = cfg_q.enable;
      REG_IN_DIM: begin
        val[DIM_W-1:0]            = cfg_q.in_w;
        val[DIM_HI_LSB +: DIM_W]  = cfg_q.in_h;
      end
      REG_WIN_START: begin
        val[DIM_W-1:0]            = cfg_q.start_x;
        val[DIM_HI_LSB +: DIM_W]  = cfg_q.start_y;
      end
      REG_OUT_DIM: begin
        val[DIM_W-1:0]            = cfg_q.out_w;
        val[DIM_HI_LSB +: DIM_W]  = cfg_q.out_h;
      end
      REG_FILL: val[PIXEL_W-1:0] = cfg_q.fill;
      REG_STATUS: begin
        val[0]                           = done_q;
        val[STAT_CNT_LSB +: FRAME_CNT_W] = frame_cnt_q;
      end
      default: val = '0;
    endcase
    return val;
  endfunction

  assign aw_hs = i_axil.awvalid && !aw_pend;
  assign w_hs  = i_axil.wvalid && !w_pend;
  assign ar_hs = i_axil.arvalid && !rvalid_q;

  // address and data may come in either order
  assign wr_addr = aw_pend ? aw_addr_q : i_axil.awaddr;
  assign wr_data = w_pend ? w_data_q : i_axil.wdata;
  assign wr_strb = w_pend ? w_strb_q : i_axil.wstrb;
  assign wr_en   = (aw_pend || aw_hs) && (w_pend || w_hs) && !bvalid_q;

  // byte lanes without strobe keep their value
  always_comb begin
    wr_old = reg_read(wr_addr);
    for (int i = 0; i < AXIL_STRB_W; i++) begin
      wr_val[8*i +: 8] = wr_strb[i] ? wr_data[8*i +: 8] : wr_old[8*i +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      aw_addr_q <= i_axil.awaddr;
    end
    if (w_hs) begin
      w_data_q <= i_axil.wdata;
      w_strb_q <= i_axil.wstrb;
    end
    if (ar_hs) begin
      rdata_q <= reg_read(i_axil.araddr);
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      aw_pend     <= 1'b0;
      w_pend      <= 1'b0;
      bvalid_q    <= 1'b0;
      rvalid_q    <= 1'b0;
      cfg_q       <= '0;
      done_q      <= 1'b0;
      frame_cnt_q <= '0;
    end else begin
      if (wr_en) begin
        aw_pend  <= 1'b0;
        w_pend   <= 1'b0;
        bvalid_q <= 1'b1;
      end else begin
        if (aw_hs) begin
          aw_pend <= 1'b1;
        end
        if (w_hs) begin
          w_pend <= 1'b1;
        end
        if (bvalid_q && i_axil.bready) begin
          bvalid_q <= 1'b0;
        end
      end

      if (ar_hs) begin
        rvalid_q <= 1'b1;
      end else if (i_axil.rready) begin
        rvalid_q <= 1'b0;
      end

      if (wr_en) begin
        case (wr_addr)
          REG_CTRL: cfg_q.enable <= wr_val[0];
          REG_IN_DIM: begin
            cfg_q.in_w <= wr_val[DIM_W-1:0];
            cfg_q.in_h <= wr_val[DIM_HI_LSB +: DIM_W];
          end
          REG_WIN_START: begin
            cfg_q.start_x <= wr_val[DIM_W-1:0];
            cfg_q.start_y <= wr_val[DIM_HI_LSB +: DIM_W];
          end
          REG_OUT_DIM: begin
            cfg_q.out_w <= wr_val[DIM_W-1:0];
            cfg_q.out_h <= wr_val[DIM_HI_LSB +: DIM_W];
          end
          REG_FILL: cfg_q.fill <= wr_val[PIXEL_W-1:0];
          // write 1 clears done, count is read-only
          REG_STATUS: begin
            if (wr_strb[0] && wr_data[0]) begin
              done_q <= 1'b0;
            end
          end
          default: ;
        endcase
      end

      // a new frame end wins over a clear in the same cycle
      if (i_frame_done) begin
        done_q      <= 1'b1;
        frame_cnt_q <= frame_cnt_q + 1'b1;
      end
    end
  end

  assign o_axil.awready = !aw_pend;
  assign o_axil.wready  = !w_pend;
  assign o_axil.bresp   = RESP_OKAY;
  assign o_axil.bvalid  = bvalid_q;
  assign o_axil.arready = !rvalid_q;
  assign o_axil.rdata   = rdata_q;
  assign o_axil.rresp   = RESP_OKAY;
  assign o_axil.rvalid  = rvalid_q;

  assign o_cfg = cfg_q;

endmodule

// File: hdl/crop_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Crop controller
// tracks the raster position of each input pixel, forwards
// window pixels, pads with the fill value, drains the rest
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module crop_ctrl
  import video_pkg::*;
  import axil_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst_n,
  input  crop_cfg_t i_cfg,
  input  in_beat_t  i_in,
  input  logic      i_in_valid,
  output logic      o_in_ready,
  output out_beat_t o_out,
  output logic      o_out_valid,
  input  logic      i_out_ready,
  output logic      o_frame_done
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ACTIVE,
    S_PAD,
    S_DRAIN
  } state_t;

  state_t               state;
  crop_cfg_t            cfg_q;
  crop_cfg_t            cfg_cur;
  dim_t                 x;
  dim_t                 y;
  logic [PIX_CNT_W-1:0] out_cnt;
  logic [PIX_CNT_W-1:0] out_cnt_nxt;
  logic [PIX_CNT_W-1:0] out_total;
  out_beat_t            out_q;
  logic                 out_valid_q;
  logic                 frame_done_q;
  logic                 can_push;
  logic                 proc;
  logic                 in_win;
  logic                 last_in;
  logic                 fwd;
  logic                 fill;
  logic                 push;
  logic                 out_done;
  logic                 finish;

  // the sof beat is handled in IDLE, before cfg_q holds it
  assign cfg_cur   = (state == S_IDLE) ? i_cfg : cfg_q;
  assign out_total = cfg_cur.out_w * cfg_cur.out_h;

  // output register free now or emptied this cycle
  assign can_push = !out_valid_q || i_out_ready;

  always_comb begin
    case (state)
      S_IDLE:   o_in_ready = i_cfg.enable && (!i_in.sof || can_push);
      S_ACTIVE: o_in_ready = can_push;
      S_DRAIN:  o_in_ready = 1'b1;
      default:  o_in_ready = 1'b0;
    endcase
  end

  // stray beats before sof are taken but not counted
  assign proc = i_in_valid && o_in_ready && ((state != S_IDLE) || i_in.sof);

  assign in_win = (x >= cfg_cur.start_x) && ((x - cfg_cur.start_x) < cfg_cur.out_w) &&
                  (y >= cfg_cur.start_y) && ((y - cfg_cur.start_y) < cfg_cur.out_h);
  assign last_in = (x == cfg_cur.in_w - 1'b1) && (y == cfg_cur.in_h - 1'b1);

  assign fwd  = proc && in_win && (out_cnt < out_total);
  assign fill = (state == S_PAD) && (out_cnt < out_total) && can_push;
  assign push = fwd || fill;

  assign out_cnt_nxt = push ? out_cnt + 1'b1 : out_cnt;
  assign out_done    = (out_cnt_nxt >= out_total);
  assign finish      = (proc && last_in && out_done) || ((state == S_PAD) && out_done);

  always_ff @(posedge clk) begin
    if ((state == S_IDLE) && proc) begin
      cfg_q <= i_cfg;
    end
    if (push) begin
      out_q.last <= out_done;
      out_q.pix  <= fwd ? i_in.pix : cfg_cur.fill;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state        <= S_IDLE;
      x            <= '0;
      y            <= '0;
      out_cnt      <= '0;
      out_valid_q  <= 1'b0;
      frame_done_q <= 1'b0;
    end else begin
      frame_done_q <= 1'b0;

      if (push) begin
        out_valid_q <= 1'b1;
      end else if (i_out_ready) begin
        out_valid_q <= 1'b0;
      end

      if (finish) begin
        state        <= S_IDLE;
        x            <= '0;
        y            <= '0;
        out_cnt      <= '0;
        frame_done_q <= 1'b1;
      end else begin
        out_cnt <= out_cnt_nxt;
        if (proc) begin
          if (x == cfg_cur.in_w - 1'b1) begin
            x <= '0;
            y <= y + 1'b1;
          end else begin
            x <= x + 1'b1;
          end
          // input over first means padding, output full first means draining
          if (last_in) begin
            state <= S_PAD;
          end else if (out_done) begin
            state <= S_DRAIN;
          end else begin
            state <= S_ACTIVE;
          end
        end
      end

      // disable aborts the frame at once
      if (!i_cfg.enable) begin
        state   <= S_IDLE;
        x       <= '0;
        y       <= '0;
        out_cnt <= '0;
      end
    end
  end

  assign o_out        = out_q;
  assign o_out_valid  = out_valid_q;
  assign o_frame_done = frame_done_q;

endmodule

// File: hdl/pixel_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel FIFO
// single clock circular buffer, valid/ready on both ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module pixel_fifo
  import video_pkg::*;
#(
  parameter type T = pixel_t
) (
  input  logic clk,
  input  logic i_rst_n,
  input  T     i_data,
  input  logic i_valid,
  output logic o_ready,
  output T     o_data,
  output logic o_valid,
  input  logic i_ready
);

  T                      mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  push;
  logic                  pop;

  assign o_ready = (count != FIFO_DEPTH);
  assign o_valid = (count != '0);
  assign push    = i_valid && o_ready;
  assign pop     = o_valid && i_ready;

  // head entry shows straight from the array
  assign o_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hdl/video_crop_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video crop engine
// register block, input and output FIFOs around the crop
// controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module video_crop_top
  import video_pkg::*;
  import axil_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst_n,
  input  axil_req_t i_axil,
  output axil_rsp_t o_axil,
  input  in_beat_t  i_pix,
  input  logic      i_pix_valid,
  output logic      o_pix_ready,
  output out_beat_t o_pix,
  output logic      o_pix_valid,
  input  logic      i_pix_ready
);

  crop_cfg_t cfg;
  logic      frame_done;
  in_beat_t  in_beat;
  logic      in_valid;
  logic      in_ready;
  out_beat_t crop_beat;
  logic      crop_valid;
  logic      crop_ready;

  crop_cfg_regs cfg_regs_i (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_axil       (i_axil),
    .o_axil       (o_axil),
    .i_frame_done (frame_done),
    .o_cfg        (cfg)
  );

  pixel_fifo #(.T(in_beat_t)) in_fifo_i (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_data  (i_pix),
    .i_valid (i_pix_valid),
    .o_ready (o_pix_ready),
    .o_data  (in_beat),
    .o_valid (in_valid),
    .i_ready (in_ready)
  );

  crop_ctrl ctrl_i (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_cfg        (cfg),
    .i_in         (in_beat),
    .i_in_valid   (in_valid),
    .o_in_ready   (in_ready),
    .o_out        (crop_beat),
    .o_out_valid  (crop_valid),
    .i_out_ready  (crop_ready),
    .o_frame_done (frame_done)
  );

  pixel_fifo #(.T(out_beat_t)) out_fifo_i (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_data  (crop_beat),
    .i_valid (crop_valid),
    .o_ready (crop_ready),
    .o_data  (o_pix),
    .o_valid (o_pix_valid),
    .i_ready (i_pix_ready)
  );

endmodule

// File: hdl/video_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video types for the crop engine
// pixel format, stream beats, geometry fields, FIFO sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package video_pkg;

  // 8 bits per colour channel
  localparam int PIXEL_W    = 24;
  localparam int DIM_W      = 12;

  // pixel FIFO sizing
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // holds width times height
  localparam int PIX_CNT_W  = 2 * DIM_W;

  typedef logic [PIXEL_W-1:0] pixel_t;
  typedef logic [DIM_W-1:0]   dim_t;

  // input beat, sof marks pixel (0,0)
  typedef struct packed {
    logic   sof;
    pixel_t pix;
  } in_beat_t;

  // output beat, last marks the final beat of the output frame
  typedef struct packed {
    logic   last;
    pixel_t pix;
  } out_beat_t;

endpackage

// File: list.f
hdl/video_pkg.sv
hdl/axil_pkg.sv
hdl/crop_cfg_regs.sv
hdl/pixel_fifo.sv
hdl/crop_ctrl.sv
hdl/video_crop_top.sv
sim/video_crop_props.sv
sim/tb_video_crop.sv

// File: sim/crop_trace.txt
# W addr data | R addr expected | P sof pixel | E last pixel | F stall (1 = random ready)
# several records may share a line, all numbers in hex
R 14 00000000
# register write and readback
W 00 00000001
W 04 00060008
W 08 00010002
W 0C 00030004
W 10 00ABCDEF
R 00 00000001
R 04 00060008
R 08 00010002
R 0C 00030004
R 10 00ABCDEF
# 8x6 frame, 4x3 window at (2,1)
P 1 100 P 0 101 P 0 102 P 0 103 P 0 104 P 0 105 P 0 106 P 0 107
P 0 110 P 0 111 P 0 112 P 0 113 P 0 114 P 0 115 P 0 116 P 0 117
P 0 120 P 0 121 P 0 122 P 0 123 P 0 124 P 0 125 P 0 126 P 0 127
P 0 130 P 0 131 P 0 132 P 0 133 P 0 134 P 0 135 P 0 136 P 0 137
P 0 140 P 0 141 P 0 142 P 0 143 P 0 144 P 0 145 P 0 146 P 0 147
P 0 150 P 0 151 P 0 152 P 0 153 P 0 154 P 0 155 P 0 156 P 0 157
E 0 112 E 0 113 E 0 114 E 0 115
E 0 122 E 0 123 E 0 124 E 0 125
E 0 132 E 0 133 E 0 134 E 1 135
F 0
# done flag and count, then clear the flag
R 14 00010001
W 14 00000001
R 14 00010000
# 4x4 frame, 2x3 window at (1,2) runs off the bottom
W 04 00040004
W 08 00020001
W 0C 00030002
P 1 200 P 0 201 P 0 202 P 0 203 P 0 210 P 0 211 P 0 212 P 0 213
P 0 220 P 0 221 P 0 222 P 0 223 P 0 230 P 0 231 P 0 232 P 0 233
E 0 221 E 0 222 E 0 231 E 0 232 E 0 ABCDEF E 1 ABCDEF
F 0
# same frame under random output stall
P 1 200 P 0 201 P 0 202 P 0 203 P 0 210 P 0 211 P 0 212 P 0 213
P 0 220 P 0 221 P 0 222 P 0 223 P 0 230 P 0 231 P 0 232 P 0 233
E 0 221 E 0 222 E 0 231 E 0 232 E 0 ABCDEF E 1 ABCDEF
F 1
# output full after 2x2, rest of the frame drained
W 08 00000000
W 0C 00020002
P 1 300 P 0 301 P 0 302 P 0 303 P 0 310 P 0 311 P 0 312 P 0 313
P 0 320 P 0 321 P 0 322 P 0 323 P 0 330 P 0 331 P 0 332 P 0 333
E 0 300 E 0 301 E 0 310 E 1 311
F 0
# next frame starts clean, random stall again
P 1 300 P 0 301 P 0 302 P 0 303 P 0 310 P 0 311 P 0 312 P 0 313
P 0 320 P 0 321 P 0 322 P 0 323 P 0 330 P 0 331 P 0 332 P 0 333
E 0 300 E 0 301 E 0 310 E 1 311
F 1
R 14 00050001

// File: sim/tb_video_crop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video crop engine testbench
// replays a trace of register accesses and pixel frames and
// checks every output beat against the expected one
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_video_crop
  import video_pkg::*;
  import axil_pkg::*;
();

  localparam int WAIT_LIMIT = 2000;

  logic      clk;
  logic      rst_n;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  in_beat_t  pix_in;
  logic      pix_in_valid;
  logic      pix_in_ready;
  out_beat_t pix_out;
  logic      pix_out_valid;
  logic      pix_out_ready;

  int        seed = 2483;
  int        frames_done = 0;
  int        errors;
  int        timeouts;
  int        frames_exp;
  in_beat_t  in_q[$];
  out_beat_t exp_q[$];

  video_crop_top dut_i (
    .clk         (clk),
    .i_rst_n     (rst_n),
    .i_axil      (axil_req),
    .o_axil      (axil_rsp),
    .i_pix       (pix_in),
    .i_pix_valid (pix_in_valid),
    .o_pix_ready (pix_in_ready),
    .o_pix       (pix_out),
    .o_pix_valid (pix_out_valid),
    .i_pix_ready (pix_out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // one negedge sees each done pulse
  always @(negedge clk) begin
    if (dut_i.frame_done) begin
      frames_done++;
    end
  end

  task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr,
                            input logic [AXIL_DATA_W-1:0] data);
    int   cyc;
    logic aw_go;
    logic w_go;
    @(negedge clk);
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = '1;
    axil_req.wvalid  = 1'b1;
    axil_req.bready  = 1'b1;
    cyc = 0;
    while (!(axil_rsp.bvalid && !axil_req.awvalid && !axil_req.wvalid)) begin
      if (cyc == WAIT_LIMIT) begin
        $display("Timeout: AXI write to address %h got no response", addr);
        timeouts++;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        axil_req.bready  = 1'b0;
        return;
      end
      aw_go = axil_req.awvalid && axil_rsp.awready;
      w_go  = axil_req.wvalid && axil_rsp.wready;
      @(negedge clk);
      cyc++;
      if (aw_go) begin
        axil_req.awvalid = 1'b0;
      end
      if (w_go) begin
        axil_req.wvalid = 1'b0;
      end
    end
    // every response is OKAY
    assert (axil_rsp.bresp == 2'b00) else begin
      errors++;
      $display("Error at %0t: write to %h got response %b, expected OKAY",
               $time, addr, axil_rsp.bresp);
    end
    // response taken at the coming rising edge
    @(negedge clk);
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr,
                           output logic [AXIL_DATA_W-1:0] data);
    int   cyc;
    logic ar_go;
    @(negedge clk);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    axil_req.rready  = 1'b1;
    cyc = 0;
    while (!(axil_rsp.rvalid && !axil_req.arvalid)) begin
      if (cyc == WAIT_LIMIT) begin
        $display("Timeout: AXI read from address %h got no data", addr);
        timeouts++;
        axil_req.arvalid = 1'b0;
        axil_req.rready  = 1'b0;
        data = 'x;
        return;
      end
      ar_go = axil_req.arvalid && axil_rsp.arready;
      @(negedge clk);
      cyc++;
      if (ar_go) begin
        axil_req.arvalid = 1'b0;
      end
    end
    data = axil_rsp.rdata;
    assert (axil_rsp.rresp == 2'b00) else begin
      errors++;
      $display("Error at %0t: read from %h got response %b, expected OKAY",
               $time, addr, axil_rsp.rresp);
    end
    @(negedge clk);
    axil_req.rready = 1'b0;
  endtask

  task automatic drive_frame();
    int cyc;
    foreach (in_q[i]) begin
      @(negedge clk);
      pix_in       = in_q[i];
      pix_in_valid = 1'b1;
      cyc = 0;
      while (!pix_in_ready) begin
        if (cyc == WAIT_LIMIT) begin
          $display("Timeout: input stream stalled at beat %0d", i);
          timeouts++;
          pix_in_valid = 1'b0;
          return;
        end
        @(negedge clk);
        cyc++;
      end
    end
    @(negedge clk);
    pix_in_valid = 1'b0;
  endtask

  task automatic collect_frame(input bit stall);
    int        cyc;
    int        idx;
    out_beat_t want;
    cyc = 0;
    idx = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      pix_out_ready = stall ? 1'($random(seed)) : 1'b1;
      if (pix_out_valid && pix_out_ready) begin
        want = exp_q.pop_front();
        assert (pix_out == want) else begin
          errors++;
          $display("Error at %0t: beat %0d got last=%0b pix=%h, expected last=%0b pix=%h",
                   $time, idx, pix_out.last, pix_out.pix, want.last, want.pix);
        end
        idx++;
        cyc = 0;
      end else if (cyc == WAIT_LIMIT) begin
        $display("Timeout: output stream stopped with %0d beats missing", exp_q.size());
        timeouts++;
        exp_q.delete();
      end else begin
        cyc++;
      end
    end
    @(negedge clk);
    pix_out_ready = 1'b0;
  endtask

  task automatic wait_frames();
    int cyc;
    cyc = 0;
    while (frames_done < frames_exp) begin
      if (cyc == WAIT_LIMIT) begin
        $display("Timeout: frame %0d never signalled done", frames_exp);
        timeouts++;
        frames_exp = frames_done;
        return;
      end
      @(negedge clk);
      cyc++;
    end
  endtask

  task automatic run_frame(input bit stall);
    frames_exp++;
    fork
      drive_frame();
      collect_frame(stall);
    join
    wait_frames();
    // output side must be empty once the frame is done
    assert (!pix_out_valid) else begin
      errors++;
      $display("Error at %0t: output beat beyond the end of the frame", $time);
    end
    in_q.delete();
  endtask

  initial begin
    int                     fd;
    int                     code;
    byte                    kind;
    string                  line;
    logic [31:0]            a;
    logic [31:0]            b;
    logic [AXIL_DATA_W-1:0] rd;
    in_beat_t               ib;
    out_beat_t              ob;
    errors        = 0;
    timeouts      = 0;
    frames_exp    = 0;
    rst_n         = 1'b0;
    axil_req      = '0;
    pix_in        = '0;
    pix_in_valid  = 1'b0;
    pix_out_ready = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    fd = $fopen("sim/crop_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file sim/crop_trace.txt");
      errors++;
    end else begin
      while ($fscanf(fd, " %c", kind) == 1) begin
        case (kind)
          "#": code = $fgets(line, fd);
          "W": begin
            code = $fscanf(fd, "%h %h", a, b);
            axil_write(a[AXIL_ADDR_W-1:0], b);
          end
          "R": begin
            code = $fscanf(fd, "%h %h", a, b);
            axil_read(a[AXIL_ADDR_W-1:0], rd);
            assert (rd === b) else begin
              errors++;
              $display("Error at %0t: register %h read %h, expected %h", $time, a, rd, b);
            end
          end
          "P": begin
            code = $fscanf(fd, "%h %h", a, b);
            ib.sof = a[0];
            ib.pix = b[PIXEL_W-1:0];
            in_q.push_back(ib);
          end
          "E": begin
            code = $fscanf(fd, "%h %h", a, b);
            ob.last = a[0];
            ob.pix  = b[PIXEL_W-1:0];
            exp_q.push_back(ob);
          end
          "F": begin
            code = $fscanf(fd, "%h", a);
            run_frame(a[0]);
          end
          default: begin
            $display("Unknown record type '%c' in the trace file", kind);
            errors++;
          end
        endcase
      end
      $fclose(fd);
    end

    errors += dut_i.ctrl_i.props_i.fail_cnt;
    $display("Checks done with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: sim/video_crop_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Crop controller properties
// stream stability under stall and the frame-done pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module video_crop_props
  import video_pkg::*;
(
  input logic      clk,
  input logic      i_rst_n,
  input in_beat_t  i_in,
  input logic      i_in_valid,
  input logic      i_in_ready,
  input out_beat_t i_out,
  input logic      i_out_valid,
  input logic      i_out_ready,
  input logic      i_frame_done
);

  int fail_cnt = 0;

  // FIFO head must wait for the controller
  in_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_in_valid && !i_in_ready |=> i_in_valid && $stable(i_in))
    else begin
      fail_cnt++;
      $error("input beat dropped or changed while stalled");
    end

  out_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_out))
    else begin
      fail_cnt++;
      $error("output beat dropped or changed while stalled");
    end

  // strobe lasts exactly one cycle
  done_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_frame_done |=> !i_frame_done)
    else begin
      fail_cnt++;
      $error("frame done held for more than one cycle");
    end

endmodule

bind crop_ctrl video_crop_props props_i (
  .clk          (clk),
  .i_rst_n      (i_rst_n),
  .i_in         (i_in),
  .i_in_valid   (i_in_valid),
  .i_in_ready   (o_in_ready),
  .i_out        (o_out),
  .i_out_valid  (o_out_valid),
  .i_out_ready  (i_out_ready),
  .i_frame_done (o_frame_done)
);
